//--- project.f
verilog/video_pkg.sv
verilog/csr_pkg.sv
verilog/window_csr.sv
verilog/window_shifter.sv
verilog/axis_window.sv
verilog/video_crop_top.sv
test/video_crop_asserts.sv
test/tb_video_crop.sv

//--- Bender.yml
package:
  name: video_crop

sources:
  # Packages first, then the crop path bottom-up
  - files:
      - verilog/video_pkg.sv
      - verilog/csr_pkg.sv
      - verilog/window_csr.sv
      - verilog/window_shifter.sv
      - verilog/axis_window.sv
      - verilog/video_crop_top.sv

  - target: test
    files:
      - test/video_crop_asserts.sv
      - test/tb_video_crop.sv

//--- test/crop_trace.txt
# W addr(hex) value : register write, then read back | M addr(hex) value : write mid next frame
# R mode : m_ready 0 always high, 1 random | F fw fh count first last nlast : frame and results
W 0 4
W 4 3
W 8 8
W c 6
R 0
F 16 12 48 52 139 6
M 0 2
F 16 12 48 52 139 6
F 16 12 48 50 137 6
R 1
F 16 12 48 50 137 6
W 0 10
W 4 7
W 8 6
W c 5
F 16 12 30 122 191 5
W 0 5
W 4 2
W 8 1
W c 1
F 16 12 1 37 37 1

//--- test/tb_video_crop.sv
`default_nettype none
`timescale 1ns/1ps

module tb_video_crop;

	localparam int MAX_CMDS = 64;

	logic                 clk;
	logic                 resetn;
	csr_pkg::axil_req_t   axil_req;
	csr_pkg::axil_rsp_t   axil_rsp;
	logic                 s_valid;
	video_pkg::pix_beat_t s_beat;
	logic                 s_ready;
	logic                 m_valid;
	video_pkg::pix_beat_t m_beat;
	logic                 m_ready;

	// Trace commands
	byte         cmd_kind [MAX_CMDS];
	int          cmd_arg  [MAX_CMDS][6];
	int          n_cmds;

	// Register model in cfg and the window of the running frame in exp_*
	int          cfg [4];
	int          exp_left;
	int          exp_top;
	int          exp_width;
	int          exp_height;
	int          got_count;
	int          got_nlast;
	int          got_first;
	int          got_last;
	int          pix_sent;
	logic        throttle;
	logic [31:0] rng;
	int          cycles = 0;
	int          cycle_limit = 0;

	video_crop_top u_video_crop_top (
		.clk      (clk),
		.resetn   (resetn),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.s_valid  (s_valid),
		.s_beat   (s_beat),
		.s_ready  (s_ready),
		.m_valid  (m_valid),
		.m_beat   (m_beat),
		.m_ready  (m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Test pattern used for stimulus and checking
	function automatic int pixel_value(int row, int col);
		return (row * 16 + col) % 256;
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic expect_equal(string what, int got, int exp);
		assert (got == exp)
		else abort_run($sformatf("** Error at %0d ns: %s is %0d, expected %0d",
			$time, what, got, exp));
	endtask

	////////////////////////////////////////
	// AXI4-Lite accesses
	////////////////////////////////////////
	task automatic write_reg(int addr, int value);
		@(negedge clk);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = csr_pkg::addr_t'(addr);
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = value;
		axil_req.wstrb   = '1;
		@(posedge clk);
		while (!axil_rsp.awready)
			@(posedge clk);
		expect_equal("wready with awready", axil_rsp.wready, 1);
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		// Response left waiting for one cycle
		@(negedge clk);
		axil_req.bready  = 1'b1;
		@(posedge clk);
		while (!axil_rsp.bvalid)
			@(posedge clk);
		expect_equal("bresp", axil_rsp.bresp, csr_pkg::RESP_OKAY);
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic check_reg(int addr, int value);
		@(negedge clk);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = csr_pkg::addr_t'(addr);
		@(posedge clk);
		while (!axil_rsp.arready)
			@(posedge clk);
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		axil_req.rready  = 1'b1;
		@(posedge clk);
		while (!axil_rsp.rvalid)
			@(posedge clk);
		expect_equal($sformatf("rdata of register %0h", addr), axil_rsp.rdata, value);
		expect_equal("rresp", axil_rsp.rresp, csr_pkg::RESP_OKAY);
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	// Registers are 12 bits wide
	task automatic set_reg(int addr, int value);
		write_reg(addr, value);
		cfg[addr / 4] = value % 4096;
		check_reg(addr, value % 4096);
	endtask

	////////////////////////////////////////
	// Video stream
	////////////////////////////////////////
	task automatic drive_frame(int fw, int fh);
		for (int r = 0; r < fh; r++) begin
			for (int c = 0; c < fw; c++) begin
				@(negedge clk);
				s_valid     = 1'b1;
				s_beat.data = video_pkg::pixel_t'(pixel_value(r, c));
				s_beat.user = (r == 0) && (c == 0);
				s_beat.last = (c == fw - 1);
				@(posedge clk);
				while (!s_ready)
					@(posedge clk);
				pix_sent++;
			end
		end
		@(negedge clk);
		s_valid = 1'b0;
	endtask

	task automatic run_frame(int idx, logic mid_write, int mid_addr, int mid_value);
		int fw;
		int fh;
		fw = cmd_arg[idx][0];
		fh = cmd_arg[idx][1];
		@(negedge clk);
		exp_left   = cfg[0];
		exp_top    = cfg[1];
		exp_width  = cfg[2];
		exp_height = cfg[3];
		got_count  = 0;
		got_nlast  = 0;
		got_first  = -1;
		got_last   = -1;
		pix_sent   = 0;
		fork
			drive_frame(fw, fh);
			if (mid_write) begin
				wait (pix_sent >= fw * fh / 2);
				set_reg(mid_addr, mid_value);
			end
		join
		while (got_count < cmd_arg[idx][2])
			@(posedge clk);
		// Idle gap so a stray beat still reaches the monitor
		repeat (2) @(negedge clk);
		expect_equal("kept pixel count", got_count, cmd_arg[idx][2]);
		expect_equal("kept pixel count vs window", got_count, exp_width * exp_height);
		expect_equal("first kept pixel", got_first, cmd_arg[idx][3]);
		expect_equal("last kept pixel", got_last, cmd_arg[idx][4]);
		expect_equal("tlast beats", got_nlast, cmd_arg[idx][5]);
		expect_equal("tlast beats vs height", got_nlast, exp_height);
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (throttle) begin
				rng     = lcg_next(rng);
				m_ready = rng[16];
			end else begin
				m_ready = 1'b1;
			end
		end
	end

	// Output monitor checks raster order inside the window
	always @(posedge clk) begin : monitor
		int col_ofs;
		int exp_row;
		int exp_col;
		if (resetn && m_valid && m_ready) begin
			col_ofs = got_count % exp_width;
			exp_col = exp_left + col_ofs;
			exp_row = exp_top + got_count / exp_width;
			assert (got_count < exp_width * exp_height)
			else abort_run($sformatf("** Error at %0d ns: extra output pixel %0d",
				$time, got_count));
			expect_equal($sformatf("pixel at row %0d col %0d", exp_row, exp_col),
				m_beat.data, pixel_value(exp_row, exp_col));
			expect_equal("tuser", m_beat.user, got_count == 0);
			expect_equal("tlast", m_beat.last, col_ofs == exp_width - 1);
			if (got_count == 0)
				got_first = m_beat.data;
			got_last = m_beat.data;
			if (m_beat.last)
				got_nlast++;
			got_count++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit)
			abort_run($sformatf("Timeout: output stalled, run exceeded %0d cycles",
				cycle_limit));
	end

	initial begin
		int    fd;
		int    code;
		int    want;
		int    total_pix;
		int    mid_addr;
		int    mid_value;
		logic  mid_write;
		string tag;
		resetn    = 1'b0;
		s_valid   = 1'b0;
		s_beat    = '0;
		m_ready   = 1'b0;
		axil_req  = '0;
		throttle  = 1'b0;
		rng       = 32'h68a4;
		cfg[0]    = 0;
		cfg[1]    = 0;
		cfg[2]    = 4095;
		cfg[3]    = 4095;
		exp_width = 1;
		n_cmds    = 0;
		total_pix = 0;
		mid_write = 1'b0;
		mid_addr  = 0;
		mid_value = 0;

		fd = $fopen("test/crop_trace.txt", "r");
		if (fd == 0)
			abort_run("Could not open the trace file test/crop_trace.txt");
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "#") begin
				code = $fgets(tag, fd);
			end else begin
				cmd_kind[n_cmds] = tag[0];
				if (tag == "F") begin
					want = 6;
					code = $fscanf(fd, "%d %d %d %d %d %d", cmd_arg[n_cmds][0],
						cmd_arg[n_cmds][1], cmd_arg[n_cmds][2], cmd_arg[n_cmds][3],
						cmd_arg[n_cmds][4], cmd_arg[n_cmds][5]);
					total_pix += cmd_arg[n_cmds][0] * cmd_arg[n_cmds][1];
				end else if (tag == "R") begin
					want = 1;
					code = $fscanf(fd, "%d", cmd_arg[n_cmds][0]);
				end else begin
					want = 2;
					code = $fscanf(fd, "%h %d", cmd_arg[n_cmds][0], cmd_arg[n_cmds][1]);
				end
				if (code != want)
					abort_run("Malformed line in the trace file");
				n_cmds++;
			end
		end
		$fclose(fd);
		cycle_limit = 4 * total_pix + 2000;

		repeat (16) @(negedge clk);
		resetn = 1'b1;
		assert (!s_ready && !m_valid && !axil_rsp.bvalid && !axil_rsp.rvalid)
		else abort_run("Handshake outputs were not idle after reset");

		for (int i = 0; i < n_cmds; i++) begin
			case (cmd_kind[i])
				"W": set_reg(cmd_arg[i][0], cmd_arg[i][1]);
				"R": throttle = (cmd_arg[i][0] != 0);
				"M": begin
					mid_write = 1'b1;
					mid_addr  = cmd_arg[i][0];
					mid_value = cmd_arg[i][1];
				end
				"F": begin
					run_frame(i, mid_write, mid_addr, mid_value);
					mid_write = 1'b0;
				end
				default: abort_run("Unknown command in the trace file");
			endcase
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/video_crop_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module video_crop_asserts (
	input  wire                   clk,
	input  wire                   resetn,
	input  wire                   s_valid,
	input  wire                   s_ready,
	input  video_pkg::pix_beat_t  s_beat,
	input  wire                   m_valid,
	input  wire                   m_ready,
	input  wire                   bvalid,
	input  wire                   bready
);

	// Stalled input beat stays put until taken
	s_beat_held: assert property (@(posedge clk) disable iff (!resetn)
		s_valid && !s_ready |=> s_valid && $stable(s_beat))
	else $error("input beat changed while stalled");

	m_valid_held: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid)
	else $error("m_valid withdrawn before transfer");

	// Write response waits for the master
	bvalid_held: assert property (@(posedge clk) disable iff (!resetn)
		bvalid && !bready |=> bvalid)
	else $error("bvalid dropped before bready");

endmodule

bind axis_window video_crop_asserts u_stream_asserts (
	.clk     (clk),
	.resetn  (resetn),
	.s_valid (s_valid),
	.s_ready (s_ready),
	.s_beat  (s_beat),
	.m_valid (m_valid),
	.m_ready (m_ready),
	.bvalid  (1'b0),
	.bready  (1'b1)
);

bind window_csr video_crop_asserts u_axil_asserts (
	.clk     (clk),
	.resetn  (resetn),
	.s_valid (1'b0),
	.s_ready (1'b1),
	.s_beat  ('0),
	.m_valid (1'b0),
	.m_ready (1'b1),
	.bvalid  (axil_rsp.bvalid),
	.bready  (axil_req.bready)
);

`default_nettype wire

//--- verilog/video_crop_top.sv
`default_nettype none
`timescale 1ns/1ps

module video_crop_top (
	input  wire                   clk,
	input  wire                   resetn,

	// Register bus
	input  csr_pkg::axil_req_t    axil_req,
	output csr_pkg::axil_rsp_t    axil_rsp,

	// Video in
	input  wire                   s_valid,
	input  video_pkg::pix_beat_t  s_beat,
	output logic                  s_ready,

	// Cropped video out
	output logic                  m_valid,
	output video_pkg::pix_beat_t  m_beat,
	input  wire                   m_ready
);

	video_pkg::win_cfg_t win_cfg;

	window_csr u_csr (
		.clk      (clk),
		.resetn   (resetn),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.win_cfg  (win_cfg)
	);

	axis_window u_window (
		.clk     (clk),
		.resetn  (resetn),
		.win_cfg (win_cfg),
		.s_valid (s_valid),
		.s_beat  (s_beat),
		.s_ready (s_ready),
		.m_valid (m_valid),
		.m_beat  (m_beat),
		.m_ready (m_ready)
	);

endmodule

`default_nettype wire

//--- verilog/axis_window.sv
`default_nettype none
`timescale 1ns/1ps

module axis_window (
	input  wire                   clk,
	input  wire                   resetn,
	input  video_pkg::win_cfg_t   win_cfg,
	input  wire                   s_valid,
	input  video_pkg::pix_beat_t  s_beat,
	output logic                  s_ready,
	output logic                  m_valid,
	output video_pkg::pix_beat_t  m_beat,
	input  wire                   m_ready
);

	typedef enum logic [1:0] {ST_IDLE, ST_GAP, ST_STREAM} state_t;

	state_t               state;
	video_pkg::pix_beat_t hold;
	logic                 hold_valid;
	logic                 hold_ready;
	logic                 hold_next;
	logic                 s_next;
	logic                 row_upd;
	logic                 fsync;
	logic                 lsync;
	video_pkg::col_t      col_idx;
	video_pkg::col_t      col_idx_next;
	video_pkg::row_t      row_idx;
	video_pkg::row_t      row_idx_next;
	logic                 need;
	logic                 sof;
	logic                 eol;

	// Held pixel leaves when sent or when outside the window
	assign hold_ready = !need || m_ready;
	assign hold_next  = hold_valid && hold_ready;
	assign s_next     = s_valid && s_ready;
	assign s_ready    = (state == ST_STREAM) && (!hold_valid || (hold_ready && !hold.last));

	assign lsync = (state == ST_GAP);
	assign fsync = lsync && s_beat.user;

	////////////////////////////////////////
	// Line sequencing
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state   <= ST_IDLE;
			row_upd <= 1'b0;
		end else begin
			row_upd <= lsync;
			case (state)
				ST_IDLE:   if (s_valid) state <= ST_GAP;
				ST_GAP:    state <= ST_STREAM;
				ST_STREAM: if (hold_next && hold.last) state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			hold_valid <= 1'b0;
		else if (s_next)
			hold_valid <= 1'b1;
		else if (hold_next)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (s_next)
			hold <= s_beat;
	end

	// col_idx tracks the held pixel, col_idx_next the one still to come
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_idx      <= '0;
			col_idx_next <= '0;
		end else if (lsync) begin
			col_idx_next <= '0;
		end else if (s_next) begin
			col_idx      <= col_idx_next;
			col_idx_next <= col_idx_next + video_pkg::col_t'(1);
		end
	end

	// Row steps in the first stream cycle, before the first capture lands
	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_idx      <= '0;
			row_idx_next <= '0;
		end else if (fsync) begin
			row_idx_next <= '0;
		end else if (row_upd) begin
			row_idx      <= row_idx_next;
			row_idx_next <= row_idx_next + video_pkg::row_t'(1);
		end
	end

	window_shifter u_shifter (
		.clk          (clk),
		.resetn       (resetn),
		.fsync        (fsync),
		.lsync        (lsync),
		.col_idx      (col_idx),
		.col_idx_next (col_idx_next),
		.col_update   (s_next),
		.row_idx      (row_idx),
		.row_idx_next (row_idx_next),
		.row_update   (row_upd),
		.win_cfg      (win_cfg),
		.need         (need),
		.sof          (sof),
		.eol          (eol)
	);

	assign m_valid = hold_valid && need;

	always_comb begin
		m_beat.data = hold.data;
		m_beat.user = sof;
		m_beat.last = eol;
	end

endmodule

`default_nettype wire

//--- verilog/window_shifter.sv
`default_nettype none
`timescale 1ns/1ps

module window_shifter (
	input  wire                 clk,
	input  wire                 resetn,
	input  wire                 fsync,
	input  wire                 lsync,
	input  video_pkg::col_t     col_idx,
	input  video_pkg::col_t     col_idx_next,
	input  wire                 col_update,
	input  video_pkg::row_t     row_idx,
	input  video_pkg::row_t     row_idx_next,
	input  wire                 row_update,
	input  video_pkg::win_cfg_t win_cfg,
	output logic                need,
	output logic                sof,
	output logic                eol
);

	video_pkg::win_cfg_t           win_q;
	logic [video_pkg::IMG_WBITS:0] col_end;
	logic [video_pkg::IMG_HBITS:0] row_end;
	video_pkg::col_t               col_last;
	logic                          col_in;
	logic                          row_in;

	// Exclusive window edges, one extra bit so left+width cannot wrap
	assign col_end  = {1'b0, win_q.left} + {1'b0, win_q.width};
	assign row_end  = {1'b0, win_q.top} + {1'b0, win_q.height};
	assign col_last = win_q.left + win_q.width - video_pkg::col_t'(1);

	// Window held for the whole frame
	always_ff @(posedge clk) begin
		if (!resetn)
			win_q <= '0;
		else if (fsync)
			win_q <= win_cfg;
	end

	////////////////////////////////////////
	// Inside flags, follow the index registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_in <= 1'b0;
			row_in <= 1'b0;
		end else begin
			if (lsync)
				col_in <= 1'b0;
			else if (col_update)
				col_in <= (col_idx_next >= win_q.left) && ({1'b0, col_idx_next} < col_end);
			if (fsync)
				row_in <= 1'b0;
			else if (row_update)
				row_in <= (row_idx_next >= win_q.top) && ({1'b0, row_idx_next} < row_end);
		end
	end

	assign need = col_in && row_in;
	assign sof  = need && (col_idx == win_q.left) && (row_idx == win_q.top);
	assign eol  = need && (col_idx == col_last);

endmodule

`default_nettype wire

//--- verilog/window_csr.sv
`default_nettype none
`timescale 1ns/1ps

module window_csr (
	input  wire                  clk,
	input  wire                  resetn,
	input  csr_pkg::axil_req_t   axil_req,
	output csr_pkg::axil_rsp_t   axil_rsp,
	output video_pkg::win_cfg_t  win_cfg
);

	typedef enum logic {ST_IDLE, ST_RESP} resp_state_t;

	resp_state_t         wr_state;
	resp_state_t         rd_state;
	video_pkg::win_cfg_t cfg_q;
	csr_pkg::data_t      rdata_q;
	csr_pkg::data_t      wr_word;
	logic                wr_accept;
	logic                rd_accept;

	// Register contents zero-extended to a bus word
	function automatic csr_pkg::data_t reg_word(csr_pkg::addr_t addr, video_pkg::win_cfg_t cfg);
		csr_pkg::data_t word;
		case (addr)
			csr_pkg::REG_LEFT:   word = csr_pkg::data_t'(cfg.left);
			csr_pkg::REG_TOP:    word = csr_pkg::data_t'(cfg.top);
			csr_pkg::REG_WIDTH:  word = csr_pkg::data_t'(cfg.width);
			csr_pkg::REG_HEIGHT: word = csr_pkg::data_t'(cfg.height);
			default:             word = '0;
		endcase
		return word;
	endfunction

	function automatic csr_pkg::data_t merge_lanes(csr_pkg::data_t cur, csr_pkg::data_t wdata,
			csr_pkg::strb_t strb);
		csr_pkg::data_t res;
		res = cur;
		for (int i = 0; i < csr_pkg::DATA_W / 8; i++) begin
			if (strb[i])
				res[8*i +: 8] = wdata[8*i +: 8];
		end
		return res;
	endfunction

	// Address and data are taken in the same cycle
	assign wr_accept = axil_req.awvalid && axil_req.wvalid && (wr_state == ST_IDLE);
	assign rd_accept = axil_req.arvalid && (rd_state == ST_IDLE);
	assign wr_word   = merge_lanes(reg_word(axil_req.awaddr, cfg_q), axil_req.wdata,
			axil_req.wstrb);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_state <= ST_IDLE;
			rd_state <= ST_IDLE;
		end else begin
			if (wr_state == ST_IDLE && wr_accept)
				wr_state <= ST_RESP;
			else if (wr_state == ST_RESP && axil_req.bready)
				wr_state <= ST_IDLE;
			if (rd_state == ST_IDLE && rd_accept)
				rd_state <= ST_RESP;
			else if (rd_state == ST_RESP && axil_req.rready)
				rd_state <= ST_IDLE;
		end
	end

	// Full frame window out of reset
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg_q.left   <= '0;
			cfg_q.top    <= '0;
			cfg_q.width  <= '1;
			cfg_q.height <= '1;
		end else if (wr_accept) begin
			case (axil_req.awaddr)
				csr_pkg::REG_LEFT:   cfg_q.left   <= wr_word[video_pkg::IMG_WBITS-1:0];
				csr_pkg::REG_TOP:    cfg_q.top    <= wr_word[video_pkg::IMG_HBITS-1:0];
				csr_pkg::REG_WIDTH:  cfg_q.width  <= wr_word[video_pkg::IMG_WBITS-1:0];
				csr_pkg::REG_HEIGHT: cfg_q.height <= wr_word[video_pkg::IMG_HBITS-1:0];
				default:             cfg_q        <= cfg_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept)
			rdata_q <= reg_word(axil_req.araddr, cfg_q);
	end

	always_comb begin
		axil_rsp.awready = wr_accept;
		axil_rsp.wready  = wr_accept;
		axil_rsp.bvalid  = (wr_state == ST_RESP);
		axil_rsp.bresp   = csr_pkg::RESP_OKAY;
		axil_rsp.arready = (rd_state == ST_IDLE);
		axil_rsp.rvalid  = (rd_state == ST_RESP);
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = csr_pkg::RESP_OKAY;
	end

	assign win_cfg = cfg_q;

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

////////////////////////////////////////
// AXI4-Lite register interface
////////////////////////////////////////
package csr_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [DATA_W/8-1:0] strb_t;
	typedef logic [1:0]          resp_t;

	localparam resp_t RESP_OKAY = 2'b00;

	// Byte offsets of the window registers
	localparam addr_t REG_LEFT   = 4'h0;
	localparam addr_t REG_TOP    = 4'h4;
	localparam addr_t REG_WIDTH  = 4'h8;
	localparam addr_t REG_HEIGHT = 4'hC;

	typedef struct packed {
		logic  awvalid;
		addr_t awaddr;
		logic  wvalid;
		data_t wdata;
		strb_t wstrb;
		logic  bready;
		logic  arvalid;
		addr_t araddr;
		logic  rready;
	} axil_req_t;

	typedef struct packed {
		logic  awready;
		logic  wready;
		logic  bvalid;
		resp_t bresp;
		logic  arready;
		logic  rvalid;
		data_t rdata;
		resp_t rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire

//--- verilog/video_pkg.sv
`default_nettype none

////////////////////////////////////////
// Pixel and image geometry types
////////////////////////////////////////
package video_pkg;

	localparam int PIXEL_W   = 8;
	localparam int IMG_WBITS = 12;
	localparam int IMG_HBITS = 12;

	typedef logic [PIXEL_W-1:0]   pixel_t;
	typedef logic [IMG_WBITS-1:0] col_t;
	typedef logic [IMG_HBITS-1:0] row_t;

	// Crop window, in frame coordinates
	typedef struct packed {
		col_t left;
		row_t top;
		col_t width;
		row_t height;
	} win_cfg_t;

	// One beat of the video stream, user is start of frame, last is end of line
	typedef struct packed {
		pixel_t data;
		logic   user;
		logic   last;
	} pix_beat_t;

endpackage

`default_nettype wire
